// File: hdl/ntm_matrix_params.svh
////////////////////////////////////////////////////////////////////////////
// NTM matrix modulo, shared sizes
// Element width, index width and operand buffer depth
////////////////////////////////////////////////////////////////////////////

`ifndef NTM_MATRIX_PARAMS_SVH
`define NTM_MATRIX_PARAMS_SVH

// Element, modulus and result width
`define NTM_DATA_WIDTH 16

// Matrix sizes and row/column indices
`define NTM_INDEX_WIDTH 8

// Operand buffer entries, power of two
`define NTM_BUFFER_DEPTH 4

// Occupancy count, holds 0 to NTM_BUFFER_DEPTH
`define NTM_COUNT_WIDTH 3

`endif

// File: hdl/ntm_matrix_pkg.sv
////////////////////////////////////////////////////////////////////////////
// NTM matrix modulo, shared types
// Element and index words used across the datapath
////////////////////////////////////////////////////////////////////////////

`include "ntm_matrix_params.svh"

package ntm_matrix_pkg;

  //////////////////////////////////////////////////////////////////////////
  // Data words
  //////////////////////////////////////////////////////////////////////////

  // Element, modulus or remainder
  typedef logic [`NTM_DATA_WIDTH-1:0] data_t;

  //////////////////////////////////////////////////////////////////////////
  // Matrix geometry
  //////////////////////////////////////////////////////////////////////////

  // Row/column size or running index
  typedef logic [`NTM_INDEX_WIDTH-1:0] index_t;

endpackage

// File: hdl/ntm_matrix_sequencer.sv
////////////////////////////////////////////////////////////////////////////
// NTM matrix sequencer
// Walks rows and columns of the incoming matrix, accepts the expected
// strobe and pushes each element with its row-last and matrix-last tags
////////////////////////////////////////////////////////////////////////////

module ntm_matrix_sequencer (
  // Global
  input  logic                   CLK,
  input  logic                   RST,

  // Control
  input  logic                   start,
  input  ntm_matrix_pkg::index_t size_i,
  input  ntm_matrix_pkg::index_t size_j,

  // Element stream
  input  logic                   data_in_i_enable,
  input  logic                   data_in_j_enable,
  input  ntm_matrix_pkg::data_t  data_in,
  input  ntm_matrix_pkg::data_t  modulo_in,

  // Towards operand buffer
  output logic                   push,
  output ntm_matrix_pkg::data_t  push_data,
  output ntm_matrix_pkg::data_t  push_modulo,
  output logic                   push_row_last,
  output logic                   push_matrix_last
);

  //////////////////////////////////////////////////////////////////////////
  // Constants
  //////////////////////////////////////////////////////////////////////////

  // FSM encoding
  localparam logic [1:0] ST_IDLE = 2'd0;
  localparam logic [1:0] ST_ROW  = 2'd1;
  localparam logic [1:0] ST_COL  = 2'd2;

  localparam ntm_matrix_pkg::index_t IDX_ZERO = '0;
  localparam ntm_matrix_pkg::index_t IDX_ONE  = 1;

  //////////////////////////////////////////////////////////////////////////
  // Signals
  //////////////////////////////////////////////////////////////////////////

  logic [1:0]             state;

  // Sizes latched at start
  ntm_matrix_pkg::index_t size_i_r;
  ntm_matrix_pkg::index_t size_j_r;

  // Position of the next expected element
  ntm_matrix_pkg::index_t idx_i;
  ntm_matrix_pkg::index_t idx_j;

  logic                   accept;
  logic                   col_end;
  logic                   row_end;

  //////////////////////////////////////////////////////////////////////////
  // Body
  //////////////////////////////////////////////////////////////////////////

  // Row head needs i strobe, rest of the row needs j strobe
  assign accept = ((state == ST_ROW) && data_in_i_enable) ||
                  ((state == ST_COL) && data_in_j_enable);

  // Last column of current row, last row of matrix
  assign col_end = (idx_j == (size_j_r - IDX_ONE));
  assign row_end = (idx_i == (size_i_r - IDX_ONE));

  // Control walk
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state            <= ST_IDLE;
      idx_i            <= IDX_ZERO;
      idx_j            <= IDX_ZERO;
      push             <= 1'b0;
      push_row_last    <= 1'b0;
      push_matrix_last <= 1'b0;
    end else begin
      // One push per accepted strobe, one cycle later
      push <= accept;

      case (state)
        ST_IDLE: begin
          if (start) begin
            idx_i <= IDX_ZERO;
            idx_j <= IDX_ZERO;
            state <= ST_ROW;
          end
        end
        ST_ROW, ST_COL: begin
          if (accept) begin
            // Tags for this element
            push_row_last    <= col_end;
            push_matrix_last <= col_end && row_end;
            if (col_end) begin
              idx_j <= IDX_ZERO;
              if (row_end) begin
                // Whole matrix seen
                state <= ST_IDLE;
              end else begin
                idx_i <= idx_i + IDX_ONE;
                state <= ST_ROW;
              end
            end else begin
              idx_j <= idx_j + IDX_ONE;
              state <= ST_COL;
            end
          end
        end
        default: begin
          state <= ST_IDLE;
        end
      endcase
    end
  end

  // Sizes and operand capture
  always_ff @(posedge CLK) begin
    if ((state == ST_IDLE) && start) begin
      size_i_r <= size_i;
      size_j_r <= size_j;
    end
    if (accept) begin
      push_data   <= data_in;
      push_modulo <= modulo_in;
    end
  end

endmodule

// File: hdl/ntm_operand_buffer.sv
////////////////////////////////////////////////////////////////////////////
// NTM operand buffer
// Show-ahead circular FIFO holding element, modulus and tag bits
////////////////////////////////////////////////////////////////////////////

`include "ntm_matrix_params.svh"

module ntm_operand_buffer (
  // Global
  input  logic                         CLK,
  input  logic                         RST,

  // Write side
  input  logic                         push,
  input  ntm_matrix_pkg::data_t        push_data,
  input  ntm_matrix_pkg::data_t        push_modulo,
  input  logic                         push_row_last,
  input  logic                         push_matrix_last,

  // Read side
  input  logic                         pop,
  output ntm_matrix_pkg::data_t        head_data,
  output ntm_matrix_pkg::data_t        head_modulo,
  output logic                         head_row_last,
  output logic                         head_matrix_last,

  // Status
  output logic                         empty,
  output logic [`NTM_COUNT_WIDTH-1:0]  count
);

  //////////////////////////////////////////////////////////////////////////
  // Constants
  //////////////////////////////////////////////////////////////////////////

  localparam int PTR_W = $clog2(`NTM_BUFFER_DEPTH);

  localparam logic [`NTM_COUNT_WIDTH-1:0] FULL_COUNT = `NTM_BUFFER_DEPTH;
  localparam logic [`NTM_COUNT_WIDTH-1:0] ONE_COUNT  = 1;

  //////////////////////////////////////////////////////////////////////////
  // Signals
  //////////////////////////////////////////////////////////////////////////

  // Storage, one array per field
  ntm_matrix_pkg::data_t mem_data   [`NTM_BUFFER_DEPTH];
  ntm_matrix_pkg::data_t mem_modulo [`NTM_BUFFER_DEPTH];
  logic                  mem_row_last    [`NTM_BUFFER_DEPTH];
  logic                  mem_matrix_last [`NTM_BUFFER_DEPTH];

  logic [PTR_W-1:0]      wr_ptr;
  logic [PTR_W-1:0]      rd_ptr;

  logic                  do_push;
  logic                  do_pop;

  //////////////////////////////////////////////////////////////////////////
  // Body
  //////////////////////////////////////////////////////////////////////////

  assign empty = (count == '0);

  // Drop push when full, ignore pop when empty
  assign do_push = push && (count != FULL_COUNT);
  assign do_pop  = pop && !empty;

  // Head entry visible without a pop
  assign head_data        = mem_data[rd_ptr];
  assign head_modulo      = mem_modulo[rd_ptr];
  assign head_row_last    = mem_row_last[rd_ptr];
  assign head_matrix_last = mem_matrix_last[rd_ptr];

  // Pointers and occupancy
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      // Pointers wrap naturally, depth is a power of two
      if (do_push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({do_push, do_pop})
        2'b10:   count <= count + ONE_COUNT;
        2'b01:   count <= count - ONE_COUNT;
        default: count <= count;
      endcase
    end
  end

  // Entry write
  always_ff @(posedge CLK) begin
    if (do_push) begin
      mem_data[wr_ptr]        <= push_data;
      mem_modulo[wr_ptr]      <= push_modulo;
      mem_row_last[wr_ptr]    <= push_row_last;
      mem_matrix_last[wr_ptr] <= push_matrix_last;
    end
  end

endmodule

// File: hdl/ntm_scalar_mod.sv
////////////////////////////////////////////////////////////////////////////
// NTM scalar modulo
// Bit-serial restoring remainder, one dividend bit per cycle,
// drives the result word and the output strobes
////////////////////////////////////////////////////////////////////////////

`include "ntm_matrix_params.svh"

module ntm_scalar_mod (
  // Global
  input  logic                  CLK,
  input  logic                  RST,

  // From operand buffer
  input  logic                  empty,
  input  ntm_matrix_pkg::data_t head_data,
  input  ntm_matrix_pkg::data_t head_modulo,
  input  logic                  head_row_last,
  input  logic                  head_matrix_last,
  output logic                  pop,

  // Result
  output ntm_matrix_pkg::data_t data_out,
  output logic                  data_out_i_enable,
  output logic                  data_out_j_enable,
  output logic                  ready
);

  //////////////////////////////////////////////////////////////////////////
  // Constants
  //////////////////////////////////////////////////////////////////////////

  localparam int W      = `NTM_DATA_WIDTH;
  localparam int STEP_W = $clog2(W);

  localparam logic [STEP_W-1:0] LAST_STEP = STEP_W'(W - 1);

  //////////////////////////////////////////////////////////////////////////
  // Signals
  //////////////////////////////////////////////////////////////////////////

  logic                  busy;
  logic [STEP_W-1:0]     step;

  // Operands, rotated dividend and partial remainder
  ntm_matrix_pkg::data_t div_r;
  ntm_matrix_pkg::data_t mod_r;
  ntm_matrix_pkg::data_t rem_r;
  logic                  row_last_r;
  logic                  matrix_last_r;

  // One restoring step
  logic [W:0]            trial;
  logic [W:0]            diff;
  ntm_matrix_pkg::data_t rem_next;
  ntm_matrix_pkg::data_t div_rot;
  ntm_matrix_pkg::data_t result;

  //////////////////////////////////////////////////////////////////////////
  // Body
  //////////////////////////////////////////////////////////////////////////

  // Take head as soon as engine is free
  assign pop = !busy && !empty;

  // Bring down next dividend bit, subtract if it fits
  assign trial    = {rem_r, div_r[W-1]};
  assign diff     = trial - {1'b0, mod_r};
  assign rem_next = (trial >= {1'b0, mod_r}) ? diff[W-1:0] : trial[W-1:0];

  // Full rotation restores the original element
  assign div_rot = {div_r[W-2:0], div_r[W-1]};

  // Zero modulus passes the element through
  assign result = (mod_r == '0) ? div_rot : rem_next;

  // Step control and output strobes
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      busy              <= 1'b0;
      step              <= '0;
      data_out          <= '0;
      data_out_i_enable <= 1'b0;
      data_out_j_enable <= 1'b0;
      ready             <= 1'b0;
    end else begin
      // Strobes are single-cycle pulses
      data_out_i_enable <= 1'b0;
      data_out_j_enable <= 1'b0;
      ready             <= 1'b0;
      if (pop) begin
        busy <= 1'b1;
        step <= '0;
      end else if (busy) begin
        step <= step + 1'b1;
        if (step == LAST_STEP) begin
          busy              <= 1'b0;
          data_out          <= result;
          data_out_j_enable <= 1'b1;
          data_out_i_enable <= row_last_r;
          ready             <= matrix_last_r;
        end
      end
    end
  end

  // Operand load and remainder datapath
  always_ff @(posedge CLK) begin
    if (pop) begin
      div_r         <= head_data;
      mod_r         <= head_modulo;
      rem_r         <= '0;
      row_last_r    <= head_row_last;
      matrix_last_r <= head_matrix_last;
    end else if (busy) begin
      div_r <= div_rot;
      rem_r <= rem_next;
    end
  end

endmodule

// File: hdl/ntm_matrix_mod.sv
////////////////////////////////////////////////////////////////////////////
// NTM matrix modulo, top level
// Sequencer feeds the operand buffer, remainder unit drains it
////////////////////////////////////////////////////////////////////////////

module ntm_matrix_mod (
  // Global
  input  logic                   CLK,
  input  logic                   RST,

  // Control
  input  logic                   start,
  output logic                   ready,

  // Matrix geometry
  input  ntm_matrix_pkg::index_t size_i,
  input  ntm_matrix_pkg::index_t size_j,

  // Element stream in
  input  logic                   data_in_i_enable,
  input  logic                   data_in_j_enable,
  input  ntm_matrix_pkg::data_t  data_in,
  input  ntm_matrix_pkg::data_t  modulo_in,

  // Result stream out
  output logic                   data_out_i_enable,
  output logic                   data_out_j_enable,
  output ntm_matrix_pkg::data_t  data_out
);

  //////////////////////////////////////////////////////////////////////////
  // Signals
  //////////////////////////////////////////////////////////////////////////

  // Sequencer to buffer
  logic                  push;
  ntm_matrix_pkg::data_t push_data;
  ntm_matrix_pkg::data_t push_modulo;
  logic                  push_row_last;
  logic                  push_matrix_last;

  // Buffer to remainder unit
  logic                  pop;
  logic                  empty;
  ntm_matrix_pkg::data_t head_data;
  ntm_matrix_pkg::data_t head_modulo;
  logic                  head_row_last;
  logic                  head_matrix_last;

  //////////////////////////////////////////////////////////////////////////
  // Body
  //////////////////////////////////////////////////////////////////////////

  // Row/column walk and tagging
  ntm_matrix_sequencer sequencer (
    .CLK              (CLK),
    .RST              (RST),
    .start            (start),
    .size_i           (size_i),
    .size_j           (size_j),
    .data_in_i_enable (data_in_i_enable),
    .data_in_j_enable (data_in_j_enable),
    .data_in          (data_in),
    .modulo_in        (modulo_in),
    .push             (push),
    .push_data        (push_data),
    .push_modulo      (push_modulo),
    .push_row_last    (push_row_last),
    .push_matrix_last (push_matrix_last)
  );

  // Elements in flight, count only watched by checks
  ntm_operand_buffer operand_buffer (
    .CLK              (CLK),
    .RST              (RST),
    .push             (push),
    .push_data        (push_data),
    .push_modulo      (push_modulo),
    .push_row_last    (push_row_last),
    .push_matrix_last (push_matrix_last),
    .pop              (pop),
    .head_data        (head_data),
    .head_modulo      (head_modulo),
    .head_row_last    (head_row_last),
    .head_matrix_last (head_matrix_last),
    .empty            (empty),
    .count            ()
  );

  // Remainder engine
  ntm_scalar_mod scalar_mod (
    .CLK               (CLK),
    .RST               (RST),
    .empty             (empty),
    .head_data         (head_data),
    .head_modulo       (head_modulo),
    .head_row_last     (head_row_last),
    .head_matrix_last  (head_matrix_last),
    .pop               (pop),
    .data_out          (data_out),
    .data_out_i_enable (data_out_i_enable),
    .data_out_j_enable (data_out_j_enable),
    .ready             (ready)
  );

endmodule

// File: testbench/ntm_matrix_mod_assert.sv
////////////////////////////////////////////////////////////////////////////
// NTM matrix modulo checks
// Buffer occupancy, output strobe pairing and quiet outputs in reset
////////////////////////////////////////////////////////////////////////////

`include "ntm_matrix_params.svh"

module ntm_matrix_mod_assert (
  input  logic                        CLK,
  input  logic                        RST,
  input  logic                        push,
  input  logic [`NTM_COUNT_WIDTH-1:0] count,
  input  logic                        data_out_i_enable,
  input  logic                        data_out_j_enable,
  input  logic                        ready
);
  timeunit 1ns;
  timeprecision 1ps;

  localparam logic [`NTM_COUNT_WIDTH-1:0] FULL_COUNT = `NTM_BUFFER_DEPTH;

  // Number of failed assertions
  int failures = 0;

  // Occupancy never beyond depth
  count_in_range: assert property (@(posedge CLK) disable iff (RST) count <= FULL_COUNT)
    else begin
      $error("operand buffer count above depth");
      failures++;
    end

  // Source keeps outstanding elements within depth
  no_overflow: assert property (@(posedge CLK) disable iff (RST)
    push |-> (count != FULL_COUNT))
    else begin
      $error("push into a full operand buffer");
      failures++;
    end

  // Row and matrix tags only ride on a data strobe
  tags_with_data: assert property (@(posedge CLK) disable iff (RST)
    (data_out_i_enable || ready) |-> data_out_j_enable)
    else begin
      $error("row or matrix strobe without data strobe");
      failures++;
    end

  // Everything quiet while in reset
  quiet_in_reset: assert property (@(posedge CLK)
    RST |-> !(push || data_out_i_enable || data_out_j_enable || ready))
    else begin
      $error("strobe active during reset");
      failures++;
    end

endmodule

// Buffer side, output strobes tied off
bind ntm_operand_buffer ntm_matrix_mod_assert buffer_checks (
  .CLK(CLK), .RST(RST), .push(push), .count(count),
  .data_out_i_enable(1'b0), .data_out_j_enable(1'b0), .ready(1'b0)
);

// Output side, buffer signals tied off
bind ntm_matrix_mod ntm_matrix_mod_assert output_checks (
  .CLK(CLK), .RST(RST), .push(1'b0), .count({`NTM_COUNT_WIDTH{1'b0}}),
  .data_out_i_enable(data_out_i_enable), .data_out_j_enable(data_out_j_enable),
  .ready(ready)
);

// File: testbench/ntm_matrix_mod_tb.sv
////////////////////////////////////////////////////////////////////////////
// NTM matrix modulo testbench
// Directed matrices against a remainder reference, in-order result monitor
////////////////////////////////////////////////////////////////////////////

`include "ntm_matrix_params.svh"

module ntm_matrix_mod_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int DEPTH          = `NTM_BUFFER_DEPTH;
  // 1 + 12 + 16 + 4 + 6 + 10 elements over all tests
  localparam int TOTAL_ELEMENTS = 49;
  localparam int CYCLE_LIMIT    = TOTAL_ELEMENTS * (`NTM_DATA_WIDTH + 8) + 200;

  logic                   CLK;
  logic                   RST;
  logic                   start;
  ntm_matrix_pkg::index_t size_i;
  ntm_matrix_pkg::index_t size_j;
  logic                   data_in_i_enable;
  logic                   data_in_j_enable;
  ntm_matrix_pkg::data_t  data_in;
  ntm_matrix_pkg::data_t  modulo_in;
  logic                   ready;
  logic                   data_out_i_enable;
  logic                   data_out_j_enable;
  ntm_matrix_pkg::data_t  data_out;

  // Expected result stream, in order
  ntm_matrix_pkg::data_t  exp_data[$];
  logic                   exp_row_last[$];
  logic                   exp_matrix_last[$];

  // Staged elements and moduli, row-major
  ntm_matrix_pkg::data_t  elem_buf[64];
  ntm_matrix_pkg::data_t  mod_buf[64];

  string cur_test = "reset";
  int    mismatch_count = 0;
  int    failure_count  = 0;
  int    sent_count     = 0;
  int    returned_count = 0;
  int    row_count      = 0;
  int    ready_count    = 0;
  int    cycles         = 0;
  int    base_returned;
  int    base_rows;
  int    base_ready;

  ntm_matrix_mod uut (
    .CLK               (CLK),
    .RST               (RST),
    .start             (start),
    .ready             (ready),
    .size_i            (size_i),
    .size_j            (size_j),
    .data_in_i_enable  (data_in_i_enable),
    .data_in_j_enable  (data_in_j_enable),
    .data_in           (data_in),
    .modulo_in         (modulo_in),
    .data_out_i_enable (data_out_i_enable),
    .data_out_j_enable (data_out_j_enable),
    .data_out          (data_out)
  );

  initial begin
    CLK = 1'b0;
    forever #5 CLK = ~CLK;
  end

  //////////////////////////////////////////////////////////////////////////
  // Reference and compare
  //////////////////////////////////////////////////////////////////////////

  // Zero modulus passes the element through
  function automatic ntm_matrix_pkg::data_t expected_remainder(
    input ntm_matrix_pkg::data_t value, input ntm_matrix_pkg::data_t modulus);
    if (modulus == '0) begin
      return value;
    end
    return value % modulus;
  endfunction

  task automatic check_data(input string what, input ntm_matrix_pkg::data_t expected,
                            input ntm_matrix_pkg::data_t actual);
    if (actual !== expected) begin
      mismatch_count++;
      $display("Mismatch in %s, %s: expected %h, actual %h", cur_test, what, expected, actual);
    end
  endtask

  task automatic check_flag(input string what, input logic expected, input logic actual);
    if (actual !== expected) begin
      mismatch_count++;
      $display("Mismatch in %s, %s: expected %b, actual %b", cur_test, what, expected, actual);
    end
  endtask

  task automatic check_total(input string what, input int expected, input int actual);
    if (actual != expected) begin
      mismatch_count++;
      $display("Mismatch in %s, %s: expected %0d, actual %0d", cur_test, what, expected,
               actual);
    end
  endtask

  task automatic finish_run();
    int assertion_count;
    // Failed assertions of both bound checkers
    assertion_count = uut.operand_buffer.buffer_checks.failures +
                      uut.output_checks.failures;
    $display("Mismatches: %0d, other errors: %0d, assertion failures: %0d",
             mismatch_count, failure_count, assertion_count);
    if (mismatch_count == 0 && failure_count == 0 && assertion_count == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  endtask

  // Result monitor, strobes sampled before the edge updates them
  always @(posedge CLK) begin
    if (!RST && data_out_j_enable) begin
      returned_count++;
      if (data_out_i_enable) row_count++;
      if (ready) ready_count++;
      if (exp_data.size() == 0) begin
        failure_count++;
        $display("Test %s: result %h arrived while none was expected", cur_test, data_out);
      end else begin
        check_data("data_out", exp_data.pop_front(), data_out);
        check_flag("data_out_i_enable", exp_row_last.pop_front(), data_out_i_enable);
        check_flag("ready", exp_matrix_last.pop_front(), ready);
      end
    end else if (!RST && (data_out_i_enable || ready)) begin
      failure_count++;
      $display("Test %s: row or matrix strobe came without a data strobe", cur_test);
    end
  end

  // Run limit
  always @(posedge CLK) begin
    cycles++;
    if (cycles >= CYCLE_LIMIT) begin
      failure_count++;
      $display("Timeout in %s: run still going after %0d cycles", cur_test, cycles);
      finish_run();
    end
  end

  //////////////////////////////////////////////////////////////////////////
  // Stimulus, all called and returning on a falling edge
  //////////////////////////////////////////////////////////////////////////

  task automatic pulse_start(input int rows, input int cols);
    start  = 1'b1;
    size_i = ntm_matrix_pkg::index_t'(rows);
    size_j = ntm_matrix_pkg::index_t'(cols);
    @(negedge CLK);
    start  = 1'b0;
  endtask

  // One strobe cycle, i for a row head, j otherwise
  task automatic pulse_strobe(input logic head, input ntm_matrix_pkg::data_t value,
                              input ntm_matrix_pkg::data_t modulus);
    data_in_i_enable = head;
    data_in_j_enable = !head;
    data_in          = value;
    modulo_in        = modulus;
    @(negedge CLK);
    data_in_i_enable = 1'b0;
    data_in_j_enable = 1'b0;
  endtask

  task automatic wait_drain();
    while (returned_count != sent_count) @(negedge CLK);
  endtask

  task automatic send_element(input int row, input int col, input int rows, input int cols,
                              input int base);
    ntm_matrix_pkg::data_t value;
    ntm_matrix_pkg::data_t modulus;
    logic                  row_last;
    value    = elem_buf[base + row * cols + col];
    modulus  = mod_buf[base + row * cols + col];
    row_last = (col == cols - 1);
    // Hold off while the buffer budget is used up
    while ((sent_count - returned_count) >= DEPTH) @(negedge CLK);
    exp_data.push_back(expected_remainder(value, modulus));
    exp_row_last.push_back(row_last);
    exp_matrix_last.push_back(row_last && (row == rows - 1));
    sent_count++;
    pulse_strobe(col == 0, value, modulus);
  endtask

  task automatic send_matrix(input int rows, input int cols, input int base,
                             input logic paced);
    pulse_start(rows, cols);
    for (int r = 0; r < rows; r++) begin
      for (int c = 0; c < cols; c++) begin
        send_element(r, c, rows, cols, base);
        if (paced) wait_drain();
      end
    end
  endtask

  task automatic begin_test(input string name);
    cur_test      = name;
    base_returned = returned_count;
    base_rows     = row_count;
    base_ready    = ready_count;
  endtask

  task automatic end_test(input int results, input int rows, input int matrices);
    wait_drain();
    check_total("results", results, returned_count - base_returned);
    check_total("row strobes", rows, row_count - base_rows);
    check_total("ready strobes", matrices, ready_count - base_ready);
  endtask

  //////////////////////////////////////////////////////////////////////////
  // Directed tests
  //////////////////////////////////////////////////////////////////////////

  task automatic test_single();
    begin_test("single 1x1");
    elem_buf[0] = 16'd1000;
    mod_buf[0]  = 16'd37;
    send_matrix(1, 1, 0, 1'b0);
    end_test(1, 1, 1);
  endtask

  task automatic test_paced_random();
    ntm_matrix_pkg::data_t modulus;
    begin_test("paced 3x4");
    modulus = ntm_matrix_pkg::data_t'($urandom_range(16'hFFFF, 1));
    for (int k = 0; k < 12; k++) begin
      elem_buf[k] = ntm_matrix_pkg::data_t'($urandom);
      mod_buf[k]  = modulus;
    end
    send_matrix(3, 4, 0, 1'b1);
    end_test(12, 3, 1);
  endtask

  task automatic test_back_to_back();
    ntm_matrix_pkg::data_t modulus;
    begin_test("back to back 4x4");
    modulus = ntm_matrix_pkg::data_t'($urandom_range(300, 2));
    for (int k = 0; k < 16; k++) begin
      elem_buf[k] = ntm_matrix_pkg::data_t'($urandom);
      mod_buf[k]  = modulus;
    end
    send_matrix(4, 4, 0, 1'b0);
    end_test(16, 4, 1);
  endtask

  task automatic test_edge_values();
    begin_test("edge values");
    elem_buf[0] = 16'h1234;
    mod_buf[0]  = 16'h0001;
    elem_buf[1] = 16'hBEEF;
    mod_buf[1]  = 16'h0000;
    // Element below modulus stays
    elem_buf[2] = 16'h0005;
    mod_buf[2]  = 16'h0009;
    elem_buf[3] = 16'hFFFF;
    mod_buf[3]  = 16'hFFFF;
    send_matrix(2, 2, 0, 1'b0);
    end_test(4, 2, 1);
  endtask

  task automatic test_wrong_strobes();
    begin_test("wrong strobes");
    // Idle, both strobe kinds ignored
    pulse_strobe(1'b1, 16'h0F0F, 16'h0003);
    pulse_strobe(1'b0, 16'h0F0F, 16'h0003);
    for (int k = 0; k < 6; k++) begin
      elem_buf[k] = ntm_matrix_pkg::data_t'(16'h0100 + 37 * k);
      mod_buf[k]  = 16'd11;
    end
    pulse_start(2, 3);
    for (int r = 0; r < 2; r++) begin
      for (int c = 0; c < 3; c++) begin
        // j strobe where a row head is due
        if (c == 0) pulse_strobe(1'b0, 16'hDEAD, 16'h0007);
        send_element(r, c, 2, 3, 0);
        // i strobe in the middle of a row
        if (c == 1) pulse_strobe(1'b1, 16'hBEEF, 16'h0005);
        // Restart attempt while busy
        if (r == 0 && c == 0) pulse_start(1, 1);
      end
    end
    end_test(6, 2, 1);
  endtask

  task automatic test_two_matrices();
    begin_test("two matrices");
    for (int k = 0; k < 10; k++) begin
      elem_buf[k] = ntm_matrix_pkg::data_t'($urandom);
      mod_buf[k]  = ntm_matrix_pkg::data_t'($urandom_range(1000, 1));
    end
    // Second start lands on the cycle after the last input
    send_matrix(2, 2, 0, 1'b0);
    send_matrix(3, 2, 4, 1'b0);
    end_test(10, 5, 2);
  endtask

  //////////////////////////////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////////////////////////////

  initial begin
    void'($urandom(4144));
    RST              = 1'b1;
    start            = 1'b0;
    size_i           = '0;
    size_j           = '0;
    data_in_i_enable = 1'b0;
    data_in_j_enable = 1'b0;
    data_in          = '0;
    modulo_in        = '0;
    repeat (8) @(negedge CLK);
    RST = 1'b0;
    @(negedge CLK);

    test_single();
    test_paced_random();
    test_back_to_back();
    test_edge_values();
    test_wrong_strobes();
    test_two_matrices();

    // Quiet period catches stray results
    cur_test = "final idle";
    repeat (`NTM_DATA_WIDTH + 4) @(negedge CLK);
    if (exp_data.size() != 0) begin
      failure_count++;
      $display("%0d expected results never arrived", exp_data.size());
    end
    finish_run();
  end

endmodule

// File: ntm_matrix_mod.f
+incdir+hdl
hdl/ntm_matrix_pkg.sv
hdl/ntm_matrix_sequencer.sv
hdl/ntm_operand_buffer.sv
hdl/ntm_scalar_mod.sv
hdl/ntm_matrix_mod.sv
testbench/ntm_matrix_mod_assert.sv
testbench/ntm_matrix_mod_tb.sv

// File: Makefile
# Verilator build and run for the NTM matrix modulo block

VERILATOR ?= verilator
TOP       ?= ntm_matrix_mod_tb
FILELIST  ?= ntm_matrix_mod.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert -Wno-fatal

# Sources come from the file list, headers from the include folder
SRCS := $(shell grep -v '^+' $(FILELIST))
HDRS := $(wildcard hdl/*.svh)
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

# Rebuilt only when a source, header or the file list changes
$(BIN): $(SRCS) $(HDRS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)

# Failure is taken from the log, an aborted run counts as failure too
run: $(BIN)
	./$(BIN) 2>&1 | tee $(LOG)
	@if grep -q "ERRORS FOUND" $(LOG); then echo "Simulation failed"; exit 1; fi
	@grep -q "NO ERRORS" $(LOG) || { echo "Simulation ended without a verdict"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)
